//--- hdl/branch_target_buffer.sv
//////////////////////////////////////////////////
// branch target buffer
// direct mapped, indexed by pc bits 4 to 2
// predicts the start of the next fetch group
// trained by every resolved taken branch
//////////////////////////////////////////////////

`timescale 1ns/1ps

module branch_target_buffer import fetch_pkg::*; (
	input  logic    clock,
	input  logic    reset,
	input  addr_t   fetch_pc,          // way 0 pc of the current group
	input  logic    rob_take_branch,   // training strobe
	input  addr_t   rob_branch_pc,
	input  addr_t   rob_target_pc,
	output addr_t   pc_predicted
);

	//////////////////////////////////////////////////
	// storage
	//////////////////////////////////////////////////
	logic [BTB_ENTRIES-1:0]  btb_valid;
	addr_t                   btb_pc     [BTB_ENTRIES];  // full branch pc, no partial tag
	addr_t                   btb_target [BTB_ENTRIES];

	btb_index_t                 train_idx;
	addr_t      [FETCH_WAYS-1:0] way_pc;
	btb_index_t [FETCH_WAYS-1:0] way_idx;
	logic       [FETCH_WAYS-1:0] way_hit;

	assign train_idx = rob_branch_pc[INST_OFFSET +: BTB_BITS];

	// reset empties every entry
	always_ff @(posedge clock) begin
		if (reset) begin
			btb_valid <= '0;
		end else if (rob_take_branch) begin
			btb_valid[train_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (rob_take_branch) begin
			btb_pc[train_idx]     <= rob_branch_pc;   // newest branch replaces the entry
			btb_target[train_idx] <= rob_target_pc;
		end
	end

	//////////////////////////////////////////////////
	// lookup, one probe per way
	//////////////////////////////////////////////////
	for (genvar w = 0; w < FETCH_WAYS; w++) begin : g_probe
		assign way_pc[w]  = fetch_pc + addr_t'(INST_BYTES * w);
		assign way_idx[w] = way_pc[w][INST_OFFSET +: BTB_BITS];
		assign way_hit[w] = btb_valid[way_idx[w]] && (btb_pc[way_idx[w]] == way_pc[w]);
	end

	// lowest hitting way decides, so scan from the top down
	always_comb begin
		pc_predicted = fetch_pc + addr_t'(GROUP_BYTES);  // fall through to the next group
		for (int w = FETCH_WAYS - 1; w >= 0; w--) begin
			if (way_hit[w]) begin
				pc_predicted = btb_target[way_idx[w]];
			end
		end
	end

endmodule

//--- hdl/fetch_pkg.sv
//////////////////////////////////////////////////
// shared sizes and types for the fetch subsystem
// address, instruction and memory word typedefs
// cache and target buffer index widths
// refill state encoding for the icache
//////////////////////////////////////////////////

package fetch_pkg;

	//////////////////////////////////////////////////
	// sizes
	//////////////////////////////////////////////////
	localparam int XLEN         = 32;    // pc and byte address width
	localparam int FETCH_WAYS   = 3;     // instructions per fetch group
	localparam int IMEM_WORDS   = 256;   // 64-bit words in instruction memory
	localparam int ICACHE_LINES = 16;    // direct mapped, one word per line
	localparam int BTB_ENTRIES  = 8;

	localparam int INST_BYTES   = 4;
	localparam int INST_OFFSET  = $clog2(INST_BYTES);    // pc bits below the instruction
	localparam int WORD_OFFSET  = 3;                     // byte offset inside a 64-bit word
	localparam int GROUP_BYTES  = INST_BYTES * FETCH_WAYS;

	localparam int WORD_BITS    = $clog2(IMEM_WORDS);
	localparam int INDEX_BITS   = $clog2(ICACHE_LINES);
	localparam int TAG_BITS     = WORD_BITS - INDEX_BITS; // rest of the word index
	localparam int BTB_BITS     = $clog2(BTB_ENTRIES);

	//////////////////////////////////////////////////
	// types
	//////////////////////////////////////////////////
	typedef logic [XLEN-1:0]       addr_t;        // byte address or pc
	typedef logic [31:0]           inst_t;
	typedef logic [63:0]           mem_word_t;    // memory word, also one cache line
	typedef logic [WORD_BITS-1:0]  word_index_t;
	typedef logic [INDEX_BITS-1:0] line_index_t;
	typedef logic [TAG_BITS-1:0]   cache_tag_t;
	typedef logic [BTB_BITS-1:0]   btb_index_t;

	// icache miss handling
	typedef enum logic [1:0] {
		RF_IDLE,      // all ports hit, or waiting to see a miss
		RF_REQUEST,   // refill_req up until the arbiter grants
		RF_WAIT       // read data returns in this cycle
	} refill_state_t;

endpackage

//--- hdl/fetch_stage.sv
//////////////////////////////////////////////////
// fetch stage
// pc register with branch redirect and stall
// per-way pc, cache address and half-word select
// registered fetch packets for FETCH_WAYS ways
//////////////////////////////////////////////////

`timescale 1ns/1ps

module fetch_stage import fetch_pkg::*; (
	input  logic                         clock,
	input  logic                         reset,
	input  logic                         stall,            // level from downstream
	input  logic                         rob_take_branch,  // resolved taken branch
	input  addr_t                        rob_target_pc,
	input  addr_t                        pc_predicted,     // from the target buffer
	input  logic      [FETCH_WAYS-1:0]   icache_hit,
	input  mem_word_t [FETCH_WAYS-1:0]   icache_data,
	output addr_t                        fetch_pc,
	output addr_t     [FETCH_WAYS-1:0]   icache_addr,
	output logic      [FETCH_WAYS-1:0]   if_valid,
	output addr_t     [FETCH_WAYS-1:0]   if_pc,
	output addr_t     [FETCH_WAYS-1:0]   if_npc,
	output inst_t     [FETCH_WAYS-1:0]   if_inst
);

	addr_t                    pc_reg;
	addr_t [FETCH_WAYS-1:0]   way_pc;     // pc of each way in the current group
	inst_t [FETCH_WAYS-1:0]   way_inst;   // selected half of each cache word
	logic                     pc_advance;

	assign fetch_pc = pc_reg;

	//////////////////////////////////////////////////
	// per-way pc and cache lookup
	//////////////////////////////////////////////////
	for (genvar w = 0; w < FETCH_WAYS; w++) begin : g_way
		if (w == 0) begin : g_first
			assign way_pc[w] = pc_reg;
		end else begin : g_next
			assign way_pc[w] = way_pc[w-1] + addr_t'(INST_BYTES);  // consecutive instructions
		end
		// cache works on whole 64-bit words
		assign icache_addr[w] = {way_pc[w][XLEN-1:WORD_OFFSET], {WORD_OFFSET{1'b0}}};
		// bit 2 picks the upper instruction of the word
		assign way_inst[w] = way_pc[w][INST_OFFSET] ? icache_data[w][63:32]
		                                            : icache_data[w][31:0];
	end

	// the whole group must be present to move on
	assign pc_advance = !stall && (&icache_hit);

	//////////////////////////////////////////////////
	// pc register
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			pc_reg <= '0;                   // fetch starts at address 0
		end else if (rob_take_branch) begin
			pc_reg <= rob_target_pc;        // redirect wins over stall
		end else if (pc_advance) begin
			pc_reg <= pc_predicted;
		end
	end

	//////////////////////////////////////////////////
	// fetch packets
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset || rob_take_branch) begin
			if_valid <= '0;                 // group on the wrong path is dropped
		end else if (pc_advance) begin
			if_valid <= '1;
		end else if (!stall) begin
			if_valid <= '0;                 // waiting on a miss
		end
	end

	// payload only loads on a real advance, otherwise holds
	always_ff @(posedge clock) begin
		if (pc_advance && !rob_take_branch) begin
			for (int w = 0; w < FETCH_WAYS; w++) begin
				if_pc[w]   <= way_pc[w];
				if_npc[w]  <= way_pc[w] + addr_t'(INST_BYTES);
				if_inst[w] <= way_inst[w];
			end
		end
	end

	// a redirect always kills the packet of the next cycle
	a_branch_kills_packet: assert property (@(posedge clock) disable iff (reset)
		rob_take_branch |=> (if_valid == '0));

endmodule

//--- hdl/fetch_top.sv
//////////////////////////////////////////////////
// fetch subsystem top level
// fetch stage, target buffer, icache,
// memory arbiter and instruction memory
//////////////////////////////////////////////////

`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       stall,
	input  logic                       rob_take_branch,
	input  addr_t                      rob_branch_pc,
	input  addr_t                      rob_target_pc,
	input  logic                       prog_we,
	input  word_index_t                prog_addr,
	input  mem_word_t                  prog_data,
	output logic  [FETCH_WAYS-1:0]     if_valid,
	output addr_t [FETCH_WAYS-1:0]     if_pc,
	output addr_t [FETCH_WAYS-1:0]     if_npc,
	output inst_t [FETCH_WAYS-1:0]     if_inst
);

	//////////////////////////////////////////////////
	// internal wires
	//////////////////////////////////////////////////
	addr_t                        fetch_pc;
	addr_t                        pc_predicted;
	addr_t     [FETCH_WAYS-1:0]   icache_addr;
	logic      [FETCH_WAYS-1:0]   icache_hit;
	mem_word_t [FETCH_WAYS-1:0]   icache_data;
	logic                         refill_req;       // icache to arbiter
	word_index_t                  refill_addr;
	logic                         refill_grant;
	logic                         inval_we;         // host write snoop
	word_index_t                  inval_addr;
	logic                         mem_we;
	logic                         mem_re;
	word_index_t                  mem_addr;
	mem_word_t                    mem_wdata;
	mem_word_t                    mem_rdata;

	fetch_stage u_fetch_stage (
		.clock, .reset, .stall, .rob_take_branch, .rob_target_pc, .pc_predicted,
		.icache_hit, .icache_data, .fetch_pc, .icache_addr,
		.if_valid, .if_pc, .if_npc, .if_inst
	);

	branch_target_buffer u_btb (
		.clock, .reset, .fetch_pc, .rob_take_branch, .rob_branch_pc, .rob_target_pc,
		.pc_predicted
	);

	icache u_icache (
		.clock, .reset, .icache_addr, .icache_hit, .icache_data,
		.refill_req, .refill_addr, .refill_grant, .mem_rdata, .inval_we, .inval_addr
	);

	imem_arbiter u_arbiter (
		.prog_we, .prog_addr, .prog_data, .refill_req, .refill_addr, .refill_grant,
		.mem_we, .mem_re, .mem_addr, .mem_wdata, .inval_we, .inval_addr
	);

	inst_mem u_inst_mem (
		.clock, .mem_we, .mem_re, .mem_addr, .mem_wdata, .mem_rdata
	);

endmodule

//--- hdl/icache.sv
//////////////////////////////////////////////////
// instruction cache
// direct mapped, one 64-bit word per line
// FETCH_WAYS combinational lookup ports
// refill FSM for the lowest missing port
// invalidation on host writes
//////////////////////////////////////////////////

`timescale 1ns/1ps

module icache import fetch_pkg::*; (
	input  logic                         clock,
	input  logic                         reset,
	input  addr_t     [FETCH_WAYS-1:0]   icache_addr,   // word aligned per port
	output logic      [FETCH_WAYS-1:0]   icache_hit,
	output mem_word_t [FETCH_WAYS-1:0]   icache_data,
	output logic                         refill_req,
	output word_index_t                  refill_addr,
	input  logic                         refill_grant,
	input  mem_word_t                    mem_rdata,     // one cycle after the grant
	input  logic                         inval_we,
	input  word_index_t                  inval_addr
);

	function automatic line_index_t line_of(word_index_t word);
		return word[INDEX_BITS-1:0];
	endfunction

	function automatic cache_tag_t tag_of(word_index_t word);
		return word[WORD_BITS-1:INDEX_BITS];
	endfunction

	//////////////////////////////////////////////////
	// line arrays
	//////////////////////////////////////////////////
	logic [ICACHE_LINES-1:0]  line_valid;
	cache_tag_t               line_tag  [ICACHE_LINES];
	mem_word_t                line_data [ICACHE_LINES];

	word_index_t [FETCH_WAYS-1:0] port_word;
	word_index_t                  first_miss;   // word of the lowest missing port
	refill_state_t                state;
	word_index_t                  miss_word;    // word being refilled
	logic                         refill_stale;
	logic                         fill;
	logic                         inval_hit;

	//////////////////////////////////////////////////
	// lookup ports
	//////////////////////////////////////////////////
	for (genvar w = 0; w < FETCH_WAYS; w++) begin : g_port
		assign port_word[w]   = icache_addr[w][WORD_OFFSET +: WORD_BITS];
		assign icache_hit[w]  = line_valid[line_of(port_word[w])]
		                     && (line_tag[line_of(port_word[w])] == tag_of(port_word[w]));
		assign icache_data[w] = line_data[line_of(port_word[w])];
	end

	always_comb begin
		first_miss = port_word[0];
		for (int w = FETCH_WAYS - 1; w >= 0; w--) begin
			if (!icache_hit[w]) begin
				first_miss = port_word[w];   // lower ways overwrite higher ones
			end
		end
	end

	//////////////////////////////////////////////////
	// refill FSM
	//////////////////////////////////////////////////
	// a host write to the word in flight means the read data is old
	assign refill_stale = inval_we && (inval_addr == miss_word);
	assign fill         = (state == RF_WAIT) && !refill_stale;
	assign refill_req   = (state == RF_REQUEST);
	assign refill_addr  = miss_word;
	assign inval_hit    = inval_we && (line_tag[line_of(inval_addr)] == tag_of(inval_addr));

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= RF_IDLE;
		end else begin
			case (state)
				RF_IDLE:    if (!(&icache_hit)) state <= RF_REQUEST;
				RF_REQUEST: if (refill_grant) state <= RF_WAIT;   // host write holds us here
				RF_WAIT:    state <= refill_stale ? RF_REQUEST : RF_IDLE;  // retry on stale
				default:    state <= RF_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == RF_IDLE && !(&icache_hit)) begin
			miss_word <= first_miss;   // held until the fill completes
		end
	end

	//////////////////////////////////////////////////
	// array update
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			line_valid <= '0;
		end else begin
			if (inval_hit) begin
				line_valid[line_of(inval_addr)] <= 1'b0;   // drop the old copy
			end
			if (fill) begin
				line_valid[line_of(miss_word)] <= 1'b1;    // fill wins on the same line
			end
		end
	end

	always_ff @(posedge clock) begin
		if (fill) begin
			line_tag[line_of(miss_word)]  <= tag_of(miss_word);
			line_data[line_of(miss_word)] <= mem_rdata;
		end
	end

	// the request must not move while the arbiter holds it off
	a_refill_addr_stable: assert property (@(posedge clock) disable iff (reset)
		refill_req && !refill_grant |=> refill_req && $stable(refill_addr));

endmodule

//--- hdl/imem_arbiter.sv
//////////////////////////////////////////////////
// instruction memory arbiter
// fixed priority, host write over cache refill
// forwards host writes as cache invalidations
//////////////////////////////////////////////////

`timescale 1ns/1ps

module imem_arbiter import fetch_pkg::*; (
	input  logic         prog_we,       // host program load
	input  word_index_t  prog_addr,
	input  mem_word_t    prog_data,
	input  logic         refill_req,    // from the icache, held until granted
	input  word_index_t  refill_addr,
	output logic         refill_grant,
	output logic         mem_we,
	output logic         mem_re,
	output word_index_t  mem_addr,
	output mem_word_t    mem_wdata,
	output logic         inval_we,
	output logic [WORD_BITS-1:0] inval_addr
);

	//////////////////////////////////////////////////
	// grant and memory port mux
	//////////////////////////////////////////////////
	always_comb begin
		// host always goes first
		mem_we       = prog_we;
		mem_re       = refill_req && !prog_we;   // refill only in a free cycle
		refill_grant = mem_re;
		mem_addr     = prog_we ? prog_addr : refill_addr;
		mem_wdata    = prog_data;                 // only the host writes

		// cache drops its copy in the same cycle as the write
		inval_we     = prog_we;
		inval_addr   = prog_addr;

		// single port memory, one access per cycle
		a_one_access: assert (!(mem_we && mem_re))
			else $error("memory read and write in the same cycle");
	end

endmodule

//--- hdl/inst_mem.sv
//////////////////////////////////////////////////
// instruction memory
// IMEM_WORDS 64-bit words, single port
// synchronous write, one cycle read latency
//////////////////////////////////////////////////

`timescale 1ns/1ps

module inst_mem import fetch_pkg::*; (
	input  logic         clock,
	input  logic         mem_we,
	input  logic         mem_re,
	input  word_index_t  mem_addr,
	input  mem_word_t    mem_wdata,
	output mem_word_t    mem_rdata    // valid the cycle after mem_re
);

	mem_word_t mem [IMEM_WORDS];   // contents come from the host port

	//////////////////////////////////////////////////
	// write port
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (mem_we) begin
			mem[mem_addr] <= mem_wdata;   // seen by reads from the next cycle
		end
	end

	//////////////////////////////////////////////////
	// registered read
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (mem_re) begin
			mem_rdata <= mem[mem_addr];
		end
	end

endmodule

//--- run.sh
#!/bin/sh
# build and run the fetch subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f src.f \
	--top-module fetch_top_tb \
	-o fetch_top_tb

./obj_dir/fetch_top_tb

//--- src.f
hdl/fetch_pkg.sv
hdl/inst_mem.sv
hdl/imem_arbiter.sv
hdl/icache.sv
hdl/branch_target_buffer.sv
hdl/fetch_stage.sv
hdl/fetch_top.sv
tests/fetch_top_tb.sv

//--- tests/fetch_top_tb.sv
//////////////////////////////////////////////////
// testbench for the fetch subsystem
// clock, reset, program load through the host port
// reference memory and target buffer models
// stimulus phases and checking assertions
//////////////////////////////////////////////////

`timescale 1ns/1ps

module fetch_top_tb import fetch_pkg::*; ();

	logic                        clock = 1'b0;
	logic                        reset;
	logic                        stall;
	logic                        rob_take_branch;
	addr_t                       rob_branch_pc;
	addr_t                       rob_target_pc;
	logic                        prog_we;
	word_index_t                 prog_addr;
	mem_word_t                   prog_data;
	logic  [FETCH_WAYS-1:0]      if_valid;
	addr_t [FETCH_WAYS-1:0]      if_pc;
	addr_t [FETCH_WAYS-1:0]      if_npc;
	inst_t [FETCH_WAYS-1:0]      if_inst;

	mem_word_t ref_mem [IMEM_WORDS];        // what the host has written
	logic [BTB_ENTRIES-1:0] model_valid = '0;
	addr_t model_pc     [BTB_ENTRIES];
	addr_t model_target [BTB_ENTRIES];

	logic  stall_q = 1'b1;
	logic  fresh;                           // packet loaded at the last edge
	logic  seen_valid = 1'b0;
	logic  have_last = 1'b0;
	addr_t last_pc;                         // way 0 pc of the previous group
	logic  redirect_pending = 1'b0;
	addr_t redirect_target;
	int    packet_count = 0;

	addr_t [FETCH_WAYS-1:0] exp_pc;
	addr_t [FETCH_WAYS-1:0] exp_npc;
	inst_t [FETCH_WAYS-1:0] exp_inst;
	addr_t                  exp_next;       // predicted start of the next group

	fetch_top u_dut (.*);

	always #2 clock = ~clock;

	// packets only change when the stage was not stalled
	assign fresh = if_valid[0] && !stall_q;

	//////////////////////////////////////////////////
	// reference models
	//////////////////////////////////////////////////
	always_comb begin
		for (int w = 0; w < FETCH_WAYS; w++) begin
			exp_pc[w]   = if_pc[0] + addr_t'(INST_BYTES * w);
			exp_npc[w]  = if_pc[w] + addr_t'(INST_BYTES);
			exp_inst[w] = if_pc[w][INST_OFFSET]
				? ref_mem[if_pc[w][WORD_OFFSET +: WORD_BITS]][63:32]   // upper half
				: ref_mem[if_pc[w][WORD_OFFSET +: WORD_BITS]][31:0];
		end
	end

	always_comb begin : predict
		addr_t      probe;
		btb_index_t idx;
		logic       found;
		exp_next = last_pc + addr_t'(GROUP_BYTES);  // fall through
		found    = 1'b0;
		for (int w = 0; w < FETCH_WAYS; w++) begin
			probe = last_pc + addr_t'(INST_BYTES * w);
			idx   = probe[INST_OFFSET +: BTB_BITS];
			if (!found && model_valid[idx] && model_pc[idx] == probe) begin
				exp_next = model_target[idx];   // lowest trained way wins
				found    = 1'b1;
			end
		end
	end

	always @(posedge clock) begin
		stall_q <= stall;
		if (fresh) begin
			packet_count     <= packet_count + 1;
			seen_valid       <= 1'b1;
			last_pc          <= if_pc[0];
			have_last        <= 1'b1;
			redirect_pending <= 1'b0;
		end
		if (rob_take_branch) begin
			have_last        <= 1'b0;      // flow restarts at the target
			redirect_pending <= 1'b1;
			redirect_target  <= rob_target_pc;
			model_valid[rob_branch_pc[INST_OFFSET +: BTB_BITS]]  <= 1'b1;
			model_pc[rob_branch_pc[INST_OFFSET +: BTB_BITS]]     <= rob_branch_pc;
			model_target[rob_branch_pc[INST_OFFSET +: BTB_BITS]] <= rob_target_pc;
		end
		if (reset) begin
			have_last   <= 1'b0;
			model_valid <= '0;
		end
	end

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////
	a_reset_idle: assert property (@(posedge clock) reset |=> (if_valid == '0))
		else begin
			$display("FAIL if_valid expected 0 got %h", $sampled(if_valid));
			abort_run();
		end

	a_first_pc: assert property (@(posedge clock) disable iff (reset)
		fresh && !seen_valid |-> (if_pc[0] == '0))
		else begin
			$display("FAIL if_pc[0] expected 0 got %h", $sampled(if_pc[0]));
			abort_run();
		end

	a_all_ways: assert property (@(posedge clock) disable iff (reset) fresh |-> (if_valid == '1))
		else begin
			$display("FAIL if_valid expected %h got %h", {FETCH_WAYS{1'b1}}, $sampled(if_valid));
			abort_run();
		end

	a_way_pc: assert property (@(posedge clock) disable iff (reset) fresh |-> (if_pc == exp_pc))
		else begin
			$display("FAIL if_pc expected %h got %h", $sampled(exp_pc), $sampled(if_pc));
			abort_run();
		end

	a_way_npc: assert property (@(posedge clock) disable iff (reset) fresh |-> (if_npc == exp_npc))
		else begin
			$display("FAIL if_npc expected %h got %h", $sampled(exp_npc), $sampled(if_npc));
			abort_run();
		end

	a_way_inst: assert property (@(posedge clock) disable iff (reset)
		fresh |-> (if_inst == exp_inst))
		else begin
			$display("FAIL if_inst expected %h got %h", $sampled(exp_inst), $sampled(if_inst));
			abort_run();
		end

	a_group_order: assert property (@(posedge clock) disable iff (reset)
		fresh && have_last && !redirect_pending |-> (if_pc[0] == exp_next))
		else begin
			$display("FAIL if_pc[0] expected %h got %h", $sampled(exp_next), $sampled(if_pc[0]));
			abort_run();
		end

	a_redirect: assert property (@(posedge clock) disable iff (reset)
		fresh && redirect_pending |-> (if_pc[0] == redirect_target))
		else begin
			$display("FAIL if_pc[0] expected %h got %h",
				$sampled(redirect_target), $sampled(if_pc[0]));
			abort_run();
		end

	// a redirect may still clear a held packet
	a_stall_hold: assert property (@(posedge clock) disable iff (reset)
		stall && !rob_take_branch && if_valid[0] |=> $stable(if_valid) && $stable(if_pc)
			&& $stable(if_npc) && $stable(if_inst))
		else begin
			$display("packet outputs changed while stall was high");
			abort_run();
		end

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////
	task automatic abort_run();
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic step();
		@(posedge clock);
		#1;                                 // drive just after the edge
	endtask

	function automatic addr_t random_pc();
		return addr_t'($urandom_range(511, 0) * INST_BYTES);
	endfunction

	task automatic host_write(input word_index_t addr, input mem_word_t data);
		prog_we       = 1'b1;
		prog_addr     = addr;
		prog_data     = data;
		ref_mem[addr] = data;
		step();
		prog_we       = 1'b0;
	endtask

	task automatic redirect(input addr_t branch_pc, input addr_t target_pc);
		rob_take_branch = 1'b1;
		rob_branch_pc   = branch_pc;
		rob_target_pc   = target_pc;
		step();
		rob_take_branch = 1'b0;
	endtask

	task automatic wait_packets(input int n);
		int target;
		int cycles;
		target = packet_count + n;
		cycles = 0;
		while (packet_count < target) begin
			step();
			cycles++;
			if (cycles > 2000) begin
				$display("timeout while waiting for %0d fetch packets", n);
				abort_run();
			end
		end
	endtask

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////
	initial begin
		void'($urandom(23));
		reset = 1'b1;
		stall = 1'b1;                       // no packets while memory is loaded
		rob_take_branch = 1'b0;
		rob_branch_pc = '0;
		rob_target_pc = '0;
		prog_we = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		repeat (8) step();
		reset = 1'b0;

		// random program
		for (int a = 0; a < IMEM_WORDS; a++) begin
			host_write(word_index_t'(a), {$urandom(), $urandom()});
		end

		// free sequential fetch through misses and hits
		stall = 1'b0;
		wait_packets(30);

		// random stalls with redirects mixed in
		for (int i = 0; i < 300; i++) begin
			stall           = ($urandom_range(2, 0) == 0);
			rob_take_branch = (i % 37 == 20);
			rob_branch_pc   = random_pc();
			rob_target_pc   = random_pc();
			step();
		end
		rob_take_branch = 1'b0;
		stall = 1'b0;
		wait_packets(5);

		// train 0x40, then come back through it from 0x30
		stall = 1'b1;
		redirect(addr_t'('h40), addr_t'('h200));   // given during stall
		stall = 1'b0;
		wait_packets(4);
		redirect(addr_t'('h7f4), addr_t'('h30));
		wait_packets(6);

		// rewrite words that sit in the cache
		redirect(addr_t'('h7f8), addr_t'(0));
		wait_packets(4);
		stall = 1'b1;
		step();
		for (int a = 0; a < 4; a++) begin
			host_write(word_index_t'(a), {$urandom(), $urandom()});
		end
		redirect(addr_t'('h7f8), addr_t'(0));
		stall = 1'b0;
		wait_packets(4);

		$display("All tests passed!");
		$finish;
	end

endmodule
